// File: list.f
+incdir+src
src/usbCtrlPkg.sv
src/setupIf.sv
src/descIf.sv
src/setupCapture.sv
src/ctrlXfrFsm.sv
src/descriptorRom.sv
src/usbCtrlSerial.sv
tests/usbCtrlSerial_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the control endpoint testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f list.f --top-module usbCtrlSerial_tb -o simv

./obj_dir/simv 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"

// File: src/ctrlXfrFsm.sv
`include "usbCtrl_cfg.svh"

module ctrlXfrFsm import usbCtrlPkg::*; (
  input  logic     i_clk,
  input  logic     i_rstN,
  input  logic     i_inGrant,
  input  logic     i_inDataFree,  // room in the IN buffer
  input  logic     i_inAcked,
  input  logic     i_outAcked,
  setupIf.seq      setupBus,
  descIf.seq       descBus,
  output logic     o_inReq,
  output logic     o_inDataPut,
  output logic     o_inDataDone,
  output logic     o_inStall,
  output devAddr_t o_devAddr
);

  ctrlState_t state;
  ctrlState_t stateNext;
  logic       stallQ;
  logic       allSentQ;        // allSent one clock late
  logic       inDoneQ;         // registered rise of allSent
  logic       saveAddrQ;       // SET_ADDRESS pending its status stage
  devAddr_t   pendAddrQ;
  devAddr_t   devAddrQ;
  logic       setupEnd;
  logic       statusEnd;
  logic       zeroLenPkt;
  logic       hasData;
  logic       isSetAddr;
  logic       badDesc;

  assign hasData   = |setupBus.lenLow;
  assign isSetAddr = setupBus.bRequest == `USB_REQ_SET_ADDRESS;
  assign badDesc   = (setupBus.bRequest == `USB_REQ_GET_DESCRIPTOR) &&
                     (setupBus.descType != `USB_DESC_DEVICE) &&
                     (setupBus.descType != `USB_DESC_CONFIG);  // answered with stall

  assign setupEnd  = (state == ctrlSetup) && setupBus.pktEnd;
  assign statusEnd = ((state == ctrlDataIn) && stallQ) ||
                     ((state == ctrlStatusIn) && i_inAcked) ||
                     ((state == ctrlStatusOut) && i_outAcked);
  assign zeroLenPkt = (setupEnd && !hasData) ||                  // no data stage
                      ((state == ctrlDataOut) && i_outAcked);    // status after OUT data

  assign o_inReq     = (state == ctrlDataIn) && !descBus.allSent;
  assign o_inDataPut = (state == ctrlDataIn) && !descBus.allSent && i_inDataFree;
  assign o_inDataDone = (inDoneQ && (state == ctrlDataIn)) || zeroLenPkt;
  assign o_inStall   = stallQ;
  assign o_devAddr   = devAddrQ;

  assign descBus.setupEnd  = setupEnd;
  assign descBus.statusEnd = statusEnd;
  assign descBus.byteSent  = o_inReq && i_inGrant && i_inDataFree;  // dataFree low holds
  assign setupBus.statusEnd = statusEnd;

  always_comb begin
    stateNext = state;
    case (state)
      ctrlIdle:      if (setupBus.setupStart) stateNext = ctrlSetup;
      ctrlSetup: begin
        if (setupBus.pktEnd) begin
          if (hasData && setupBus.dirIn) stateNext = ctrlDataIn;
          else if (hasData)              stateNext = ctrlDataOut;
          else                           stateNext = ctrlStatusIn;
        end
      end
      ctrlDataIn: begin
        if (stallQ)                              stateNext = ctrlIdle;
        else if (i_inAcked && descBus.allSent)   stateNext = ctrlStatusOut;
      end
      ctrlDataOut:   if (i_outAcked) stateNext = ctrlStatusIn;
      ctrlStatusIn:  if (i_inAcked)  stateNext = ctrlIdle;
      ctrlStatusOut: if (i_outAcked) stateNext = ctrlIdle;
      default:       stateNext = ctrlIdle;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      state     <= ctrlIdle;
      stallQ    <= 1'b0;
      allSentQ  <= 1'b0;
      inDoneQ   <= 1'b0;
    end else begin
      state     <= stateNext;
      stallQ    <= setupEnd && badDesc;
      allSentQ  <= descBus.allSent;
      inDoneQ   <= descBus.allSent && !allSentQ;  // last IN byte went out
    end
  end

  // status token still uses the old address, so switch after it
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      saveAddrQ <= 1'b0;
      pendAddrQ <= '0;
      devAddrQ  <= '0;
    end else begin
      if (setupEnd && isSetAddr) pendAddrQ <= setupBus.newAddr;
      if (statusEnd && saveAddrQ) begin
        saveAddrQ <= 1'b0;
        devAddrQ  <= pendAddrQ;
      end else if (setupEnd && isSetAddr) begin
        saveAddrQ <= 1'b1;
      end
    end
  end

  // stall only ends the transfer from the IN data stage
  assert property (@(posedge i_clk) disable iff (!i_rstN) o_inStall |-> state == ctrlDataIn)
    else $error("stall outside the IN data stage");

endmodule

// File: src/descIf.sv
interface descIf ();

  // sequencer side
  logic setupEnd;   // setup stage done, load rom pointers
  logic statusEnd;  // transfer done, clear pointers
  logic byteSent;   // one IN byte accepted

  // rom side
  logic allSent;    // reply length reached

  modport seq (output setupEnd, statusEnd, byteSent,
               input  allSent);

  modport rom (input  setupEnd, statusEnd, byteSent,
               output allSent);

endinterface

// File: src/descriptorRom.sv
`include "usbCtrl_cfg.svh"

module descriptorRom import usbCtrlPkg::*; (
  input  logic  i_clk,
  input  logic  i_rstN,
  setupIf.rom   setupBus,
  descIf.rom    descBus,
  output byte_t o_data    // byte at current rom address
);

  romAddr_t romAddr;
  romAddr_t romLen;       // full descriptor length
  romAddr_t byteCnt;      // bytes accepted so far
  logic     getDesc;
  logic     isDev;
  logic     isCfg;

  assign getDesc = setupBus.bRequest == `USB_REQ_GET_DESCRIPTOR;
  assign isDev   = getDesc && (setupBus.descType == `USB_DESC_DEVICE);
  assign isCfg   = getDesc && (setupBus.descType == `USB_DESC_CONFIG);

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      romAddr <= '0;
      romLen  <= '0;
      byteCnt <= '0;
    end else if (descBus.statusEnd) begin
      romAddr <= '0;
      romLen  <= '0;
      byteCnt <= '0;
    end else if (descBus.byteSent) begin
      romAddr <= romAddr + 7'd1;
      byteCnt <= byteCnt + 7'd1;
    end else if (descBus.setupEnd) begin
      romAddr <= isCfg ? `USB_CFG_DESC_BASE : 7'd0;
      if (isDev) romLen <= `USB_DEV_DESC_LEN;
      else if (isCfg) romLen <= `USB_CFG_DESC_LEN;  // other types keep 0 and send nothing
    end
  end

  // stop at the shorter of descriptor and host request
  assign descBus.allSent = (byteCnt == romLen) || ({1'b0, byteCnt} == setupBus.lenLow);

  always_comb begin
    case (romAddr)
      // device descriptor per USB spec 9.6.1
      7'h00: o_data = {1'b0, `USB_DEV_DESC_LEN};    // bLength
      7'h01: o_data = `USB_DESC_DEVICE;
      7'h02: o_data = 8'h00;                        // bcdUSB 2.00
      7'h03: o_data = 8'h02;
      7'h04: o_data = 8'h00;                        // class per interface
      7'h05: o_data = 8'h00;
      7'h06: o_data = 8'h00;
      7'h07: o_data = `USB_MAX_IN_PKT;              // bMaxPacketSize0
      7'h08: o_data = 8'(`USB_VENDOR_ID);           // idVendor lsb first
      7'h09: o_data = 8'(`USB_VENDOR_ID >> 8);
      7'h0a: o_data = 8'(`USB_PRODUCT_ID);
      7'h0b: o_data = 8'(`USB_PRODUCT_ID >> 8);
      7'h0c: o_data = 8'h00;                        // bcdDevice
      7'h0d: o_data = 8'h00;
      7'h0e: o_data = 8'h00;                        // no string descriptors
      7'h0f: o_data = 8'h00;
      7'h10: o_data = 8'h00;
      7'h11: o_data = 8'd1;                         // bNumConfigurations
      // configuration descriptor per USB spec 9.6.2
      7'h12: o_data = 8'd9;
      7'h13: o_data = `USB_DESC_CONFIG;
      7'h14: o_data = {1'b0, `USB_CFG_DESC_LEN};    // wTotalLength
      7'h15: o_data = 8'h00;
      7'h16: o_data = 8'd1;                         // one interface
      7'h17: o_data = 8'd1;                         // bConfigurationValue
      7'h18: o_data = 8'h00;
      7'h19: o_data = 8'hc0;                        // self powered
      7'h1a: o_data = 8'd50;                        // 100 mA
      // vendor class interface descriptor
      7'h1b: o_data = 8'd9;
      7'h1c: o_data = `USB_DESC_INTERFACE;
      7'h1d: o_data = 8'h00;                        // bInterfaceNumber
      7'h1e: o_data = 8'h00;
      7'h1f: o_data = 8'd2;                         // two bulk endpoints
      7'h20: o_data = `USB_CLASS_VENDOR;
      7'h21: o_data = 8'h00;
      7'h22: o_data = 8'h00;
      7'h23: o_data = 8'h00;
      // bulk OUT endpoint 1
      7'h24: o_data = 8'd7;
      7'h25: o_data = `USB_DESC_ENDPOINT;
      7'h26: o_data = 8'h01;
      7'h27: o_data = `USB_EP_BULK;
      7'h28: o_data = `USB_MAX_OUT_PKT;             // wMaxPacketSize
      7'h29: o_data = 8'h00;
      7'h2a: o_data = 8'h00;                        // bInterval unused for bulk
      // bulk IN endpoint 1
      7'h2b: o_data = 8'd7;
      7'h2c: o_data = `USB_DESC_ENDPOINT;
      7'h2d: o_data = 8'h81;
      7'h2e: o_data = `USB_EP_BULK;
      7'h2f: o_data = `USB_MAX_IN_PKT;
      7'h30: o_data = 8'h00;
      7'h31: o_data = 8'h00;
      default: o_data = 8'h00;
    endcase
  end

  // sequencer stops puts at allSent, so count stays within the loaded length
  assert property (@(posedge i_clk) disable iff (!i_rstN) byteCnt <= romLen)
    else $error("descriptor byte count past its length");

endmodule

// File: src/setupCapture.sv
`include "usbCtrl_cfg.svh"

module setupCapture import usbCtrlPkg::*; (
  input  logic    i_clk,
  input  logic    i_rstN,
  input  logic    i_dataAvail,  // out ep holds a packet
  input  logic    i_grant,
  input  logic    i_setup,      // high from SETUP token until next OUT token
  input  byte_t   i_data,
  setupIf.capture setupBus
);

  logic      availQ;              // dataAvail one clock late
  logic      validQ;              // byte strobe of last cycle
  logic      setupStartQ;
  logic      pktEndQ;
  logic      storeByte;
  setupIdx_t byteIdx;             // next free slot
  byte_t     setupMem [`USB_SETUP_BYTES];
  word_t     wValue;

  assign storeByte = i_setup && validQ;  // data lags its strobe by one clock

  // edge pulses land one clock after the dataAvail edge
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      availQ      <= 1'b0;
      validQ      <= 1'b0;
      setupStartQ <= 1'b0;
      pktEndQ     <= 1'b0;
    end else begin
      availQ      <= i_dataAvail;
      validQ      <= i_dataAvail && i_grant;
      setupStartQ <= i_dataAvail && !availQ && i_setup;  // rise on a SETUP pkt
      pktEndQ     <= !i_dataAvail && availQ;             // fall, any pkt
    end
  end

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      byteIdx <= '0;
    end else if (setupBus.statusEnd) begin
      byteIdx <= '0;                       // ready for the next request
    end else if (storeByte) begin
      byteIdx <= byteIdx + 4'd1;
    end
  end

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      for (int i = 0; i < `USB_SETUP_BYTES; i++) begin
        setupMem[i] <= '0;
      end
    end else if (storeByte) begin
      setupMem[byteIdx[2:0]] <= i_data;
    end
  end

  assign wValue              = {setupMem[3], setupMem[2]};
  assign setupBus.dirIn      = setupMem[0][7];  // bmRequestType direction
  assign setupBus.bRequest   = setupMem[1];
  assign setupBus.descType   = wValue[15:8];
  assign setupBus.newAddr    = wValue[6:0];
  assign setupBus.lenLow     = setupMem[6];     // wLength high byte ignored
  assign setupBus.setupStart = setupStartQ;
  assign setupBus.pktEnd     = pktEndQ;

  // a SETUP packet is eight bytes, so nothing lands past the last slot
  assert property (@(posedge i_clk) disable iff (!i_rstN)
    storeByte |-> byteIdx < `USB_SETUP_BYTES)
    else $error("SETUP byte index ran past the packet");

endmodule

// File: src/setupIf.sv
interface setupIf import usbCtrlPkg::*; ();

  logic     dirIn;       // bmRequestType[7], device to host
  byte_t    bRequest;
  byte_t    descType;    // wValue high byte
  devAddr_t newAddr;     // wValue low 7 bits
  byte_t    lenLow;      // wLength low byte
  logic     setupStart;  // SETUP packet begins
  logic     pktEnd;      // dataAvail fell
  logic     statusEnd;   // transfer finished

  modport capture (output dirIn, bRequest, descType, newAddr, lenLow,
                   output setupStart, pktEnd, input statusEnd);
  modport seq     (input dirIn, bRequest, descType, newAddr, lenLow,
                   input setupStart, pktEnd, output statusEnd);
  modport rom     (input bRequest, descType, lenLow);

endinterface

// File: src/usbCtrlPkg.sv
package usbCtrlPkg;

  // one byte on the endpoint data path
  typedef logic [7:0] byte_t;

  // address assigned by the host
  typedef logic [6:0] devAddr_t;

  // rom address and byte count, 50 bytes fit
  typedef logic [6:0] romAddr_t;

  // slot of a byte inside the SETUP packet
  typedef logic [3:0] setupIdx_t;

  // two-byte SETUP field, little endian on the wire
  typedef logic [15:0] word_t;

  // stages of a control transfer
  typedef enum logic [2:0] {
    ctrlIdle,       // waiting for SETUP token
    ctrlSetup,      // SETUP data arriving
    ctrlDataIn,     // device to host data
    ctrlDataOut,    // host to device data
    ctrlStatusIn,   // zero-length IN handshake
    ctrlStatusOut   // zero-length OUT handshake
  } ctrlState_t;

endpackage

// File: src/usbCtrlSerial.sv
module usbCtrlSerial import usbCtrlPkg::*; (
  input  logic     i_clk,
  input  logic     i_rstN,
  output devAddr_t o_devAddr,       // assigned by host

  // out endpoint
  output logic     o_outEp_req,
  input  logic     i_outEp_grant,
  input  logic     i_outEp_dataAvail,
  input  logic     i_outEp_setup,
  output logic     o_outEp_dataGet,
  input  byte_t    i_outEp_data,
  input  logic     i_outEp_acked,

  // in endpoint
  output logic     o_inEp_req,
  input  logic     i_inEp_grant,
  input  logic     i_inEp_dataFree,
  output logic     o_inEp_dataPut,
  output byte_t    o_inEp_data,
  output logic     o_inEp_dataDone,
  output logic     o_inEp_stall,
  input  logic     i_inEp_acked
);

  setupIf setupBus ();
  descIf  descBus ();

  assign o_outEp_req     = i_outEp_dataAvail;  // always drain the out ep
  assign o_outEp_dataGet = i_outEp_dataAvail;

  setupCapture uSetup (.i_clk, .i_rstN, .i_dataAvail(i_outEp_dataAvail),
    .i_grant(i_outEp_grant), .i_setup(i_outEp_setup), .i_data(i_outEp_data),
    .setupBus(setupBus.capture));

  ctrlXfrFsm uFsm (.i_clk, .i_rstN, .i_inGrant(i_inEp_grant),
    .i_inDataFree(i_inEp_dataFree), .i_inAcked(i_inEp_acked), .i_outAcked(i_outEp_acked),
    .setupBus(setupBus.seq), .descBus(descBus.seq), .o_inReq(o_inEp_req),
    .o_inDataPut(o_inEp_dataPut), .o_inDataDone(o_inEp_dataDone),
    .o_inStall(o_inEp_stall), .o_devAddr);

  descriptorRom uRom (.i_clk, .i_rstN, .setupBus(setupBus.rom), .descBus(descBus.rom),
    .o_data(o_inEp_data));

endmodule

// File: src/usbCtrl_cfg.svh
`ifndef USBCTRL_CFG_SVH
`define USBCTRL_CFG_SVH

`define USB_MAX_IN_PKT          8'd32     // bMaxPacketSize0 and bulk IN size
`define USB_MAX_OUT_PKT         8'd8      // bulk OUT size

`define USB_VENDOR_ID           16'h0525
`define USB_PRODUCT_ID          16'ha4a6  // serial gadget

`define USB_REQ_GET_DESCRIPTOR  8'd6      // bRequest codes, USB spec 9.4
`define USB_REQ_SET_ADDRESS     8'd5

`define USB_DESC_DEVICE         8'd1      // bDescriptorType codes
`define USB_DESC_CONFIG         8'd2
`define USB_DESC_INTERFACE      8'd4
`define USB_DESC_ENDPOINT       8'd5

`define USB_CLASS_VENDOR        8'hff
`define USB_EP_BULK             8'd2      // bmAttributes transfer type

`define USB_DEV_DESC_LEN        7'd18
`define USB_CFG_DESC_LEN        7'd32     // 9 + 9 + 7 + 7
`define USB_CFG_DESC_BASE       7'd18     // config descriptor follows device descriptor
`define USB_SETUP_BYTES         4'd8

`endif

// File: tests/usbCtrlSerial_tb.sv
`include "usbCtrl_cfg.svh"

module usbCtrlSerial_tb import usbCtrlPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_TESTS    = 5;
  localparam int TEST_CYCLES  = 2000;  // budget per test for the watchdog
  localparam int WAIT_LIMIT   = 500;   // cycles allowed for one handshake

  logic     clk, rstN;
  devAddr_t devAddr;
  logic     outEpReq, outEpGrant, outEpDataAvail, outEpSetup, outEpDataGet, outEpAcked;
  byte_t    outEpData;
  logic     inEpReq, inEpGrant, inEpDataFree, inEpDataPut, inEpDataDone, inEpStall;
  logic     inEpAcked;
  byte_t    inEpData;

  logic [15:0] lfsr;                       // random source
  int expBase, expLen;                     // window of descByte the comparer expects
  int putCnt, doneCnt, stallCnt;           // seen since armCompare
  int errCnt, errStart, passCnt, failCnt, testNum;

  usbCtrlSerial UUT (.i_clk(clk), .i_rstN(rstN), .o_devAddr(devAddr),
    .o_outEp_req(outEpReq), .i_outEp_grant(outEpGrant), .i_outEp_dataAvail(outEpDataAvail),
    .i_outEp_setup(outEpSetup), .o_outEp_dataGet(outEpDataGet), .i_outEp_data(outEpData),
    .i_outEp_acked(outEpAcked), .o_inEp_req(inEpReq), .i_inEp_grant(inEpGrant),
    .i_inEp_dataFree(inEpDataFree), .o_inEp_dataPut(inEpDataPut), .o_inEp_data(inEpData),
    .o_inEp_dataDone(inEpDataDone), .o_inEp_stall(inEpStall), .i_inEp_acked(inEpAcked));

  // standard device descriptor then configuration set with zeros elsewhere
  function automatic byte_t descByte(input int idx);
    logic [15:0] vid;
    logic [15:0] pid;
    byte_t       b;
    vid = `USB_VENDOR_ID;
    pid = `USB_PRODUCT_ID;
    case (idx)
      0:      b = 8'(`USB_DEV_DESC_LEN);   // bLength
      1:      b = `USB_DESC_DEVICE;
      3:      b = 8'h02;                   // bcdUSB high byte
      7, 47:  b = `USB_MAX_IN_PKT;         // ep0 size and IN ep size
      8:      b = vid[7:0];
      9:      b = vid[15:8];
      10:     b = pid[7:0];
      11:     b = pid[15:8];
      17:     b = 8'd1;                    // one configuration
      18, 27: b = 8'd9;                    // config and interface bLength
      19:     b = `USB_DESC_CONFIG;
      20:     b = 8'(`USB_CFG_DESC_LEN);   // wTotalLength low
      22, 23: b = 8'd1;                    // interfaces and config value
      25:     b = 8'hc0;
      26:     b = 8'd50;                   // 100 mA
      28:     b = `USB_DESC_INTERFACE;
      31:     b = 8'd2;                    // endpoint count
      32:     b = `USB_CLASS_VENDOR;
      36, 43: b = 8'd7;
      37, 44: b = `USB_DESC_ENDPOINT;
      38:     b = 8'h01;                   // OUT ep 1
      39, 46: b = `USB_EP_BULK;
      40:     b = `USB_MAX_OUT_PKT;        // OUT ep size
      45:     b = 8'h81;                   // IN ep 1
      default: b = 8'h00;
    endcase
    return b;
  endfunction

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);  // galois with taps 16 14 13 11
  endfunction

  task automatic randomBits(input int n, output logic [15:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      val  = {val[14:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);  // one step per bit
    end
  endtask

  // bytes in wire order with byte 0 in the low bits
  function automatic logic [63:0] setupPkt(input byte_t reqType, input byte_t req,
                                           input logic [15:0] wValue,
                                           input logic [15:0] wLength);
    return {wLength, 16'h0000, wValue, req, reqType};
  endfunction

  task automatic checkValue(input int got, input int exp, input string what);
    assert (got == exp) else begin
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errCnt++;
    end
  endtask

  task automatic armCompare(input int base, input int len);
    expBase  = base;
    expLen   = len;
    putCnt   = 0;
    doneCnt  = 0;
    stallCnt = 0;
    errStart = errCnt;
  endtask

  task automatic reportTest(input string name);
    testNum++;
    if (errCnt == errStart) begin
      passCnt++;
      $display("test %0d %s: pass", testNum, name);
    end else begin
      failCnt++;
      $display("test %0d %s: fail", testNum, name);
    end
  endtask

  // starts on a falling edge and drives byte k one clock after its strobe
  task automatic sendSetup(input logic [63:0] pkt);
    outEpSetup     = 1'b1;
    outEpDataAvail = 1'b1;
    outEpGrant     = 1'b1;
    for (int k = 0; k < 8; k++) begin
      @(negedge clk);
      outEpData = pkt[8*k +: 8];
      if (k == 7) begin
        outEpDataAvail = 1'b0;  // last strobe was in the previous cycle
        outEpGrant     = 1'b0;
      end
    end
    @(negedge clk);
    outEpSetup = 1'b0;
  endtask

  // which selects dataDone (0) or stall (1)
  task automatic waitFor(input int which, input string what);
    int n;
    n = 0;
    while (((which == 0) ? doneCnt : stallCnt) == 0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    assert (((which == 0) ? doneCnt : stallCnt) != 0) else begin
      $display("Timed out at %0t waiting for %s", $time, what);
      errCnt++;
    end
  endtask

  task automatic getDescriptor(input byte_t dType, input logic [15:0] wLen, input int base,
                               input int descLen, input bit gapped);
    logic [15:0] rnd;
    int          n;
    int          nExp;
    nExp = (int'(wLen) < descLen) ? int'(wLen) : descLen;  // reply is the shorter one
    armCompare(base, nExp);
    sendSetup(setupPkt(8'h80, `USB_REQ_GET_DESCRIPTOR, {dType, 8'h00}, wLen));
    n = 0;
    while (doneCnt == 0 && n < WAIT_LIMIT) begin
      if (gapped) begin
        randomBits(1, rnd);
        inEpDataFree = rnd[0];             // buffer full when low
      end
      @(negedge clk);
      n++;
    end
    inEpDataFree = 1'b1;
    assert (doneCnt != 0) else begin
      $display("Timed out at %0t waiting for the end of the IN data stage", $time);
      errCnt++;
    end
    inEpAcked = 1'b1;                      // host acks the last data packet
    @(negedge clk);
    inEpAcked  = 1'b0;
    outEpAcked = 1'b1;                     // zero-length status OUT
    @(negedge clk);
    outEpAcked = 1'b0;
    @(negedge clk);
    checkValue(putCnt, nExp, "IN byte count");
    checkValue(doneCnt, 1, "dataDone pulse count");
    checkValue(stallCnt, 0, "stall pulse count");
    checkValue(int'(inEpReq), 0, "o_inEp_req after status");
  endtask

  task automatic stallRequest();
    armCompare(0, 0);
    sendSetup(setupPkt(8'h80, `USB_REQ_GET_DESCRIPTOR, {8'd3, 8'h00}, 16'd64));
    waitFor(1, "o_inEp_stall");
    repeat (4) @(negedge clk);             // window for a second pulse
    checkValue(stallCnt, 1, "stall pulse count");
    checkValue(putCnt, 0, "IN byte count");
    checkValue(doneCnt, 0, "dataDone pulse count");
  endtask

  task automatic setAddress();
    logic [15:0] rnd;
    devAddr_t    newAddr;
    devAddr_t    oldAddr;
    randomBits(7, rnd);
    oldAddr = devAddr;
    newAddr = rnd[6:0];
    if (newAddr == oldAddr) newAddr = newAddr ^ 7'h01;  // make the change visible
    armCompare(0, 0);
    sendSetup(setupPkt(8'h00, `USB_REQ_SET_ADDRESS, {9'h000, newAddr}, 16'd0));
    waitFor(0, "the zero-length dataDone");
    checkValue(int'(devAddr), int'(oldAddr), "o_devAddr before status");
    inEpAcked = 1'b1;                      // status IN ends the transfer
    @(negedge clk);
    inEpAcked = 1'b0;
    checkValue(int'(devAddr), int'(newAddr), "o_devAddr after status");
    checkValue(doneCnt, 1, "dataDone pulse count");
    checkValue(putCnt, 0, "IN byte count");
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // every accepted IN byte against the reference layout
  always @(posedge clk) begin
    if (rstN) begin
      if (inEpDataPut && inEpGrant) begin
        assert (putCnt < expLen) else begin
          $display("IN byte %0d sent past the expected reply length at %0t", putCnt, $time);
          errCnt++;
        end
        assert (inEpData == descByte(expBase + putCnt)) else begin
          $display("Fail at %0t: IN byte %0d is %02h, expected %02h", $time, putCnt,
                   inEpData, descByte(expBase + putCnt));
          errCnt++;
        end
        putCnt++;
      end
      // OUT ep is drained whenever it holds data
      assert (outEpReq == outEpDataAvail && outEpDataGet == outEpDataAvail) else begin
        $display("Fail at %0t: OUT ep req %0b and dataGet %0b with dataAvail %0b", $time,
                 outEpReq, outEpDataGet, outEpDataAvail);
        errCnt++;
      end
      if (inEpDataDone) doneCnt++;
      if (inEpStall) stallCnt++;
    end
  end

  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + NUM_TESTS * TEST_CYCLES));
    $display("Simulation ran past its time limit and was stopped");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rstN = 1'b0;
    outEpGrant = 1'b0;
    outEpDataAvail = 1'b0;
    outEpSetup = 1'b0;
    outEpData = 8'h00;
    outEpAcked = 1'b0;
    inEpGrant = 1'b1;                      // IN endpoint always granted
    inEpDataFree = 1'b1;
    inEpAcked = 1'b0;
    lfsr = 16'd17;
    errCnt = 0;
    passCnt = 0;
    failCnt = 0;
    testNum = 0;
    armCompare(0, 0);
    repeat (RESET_CYCLES) @(negedge clk);
    rstN = 1'b1;
    @(negedge clk);
    checkValue(int'(devAddr), 0, "o_devAddr after reset");
    checkValue(int'({inEpReq, inEpDataPut, inEpDataDone, inEpStall}), 0,
               "IN strobes after reset");
    getDescriptor(`USB_DESC_DEVICE, 16'd64, 0, int'(`USB_DEV_DESC_LEN), 1'b0);
    reportTest("device descriptor, long request");
    getDescriptor(`USB_DESC_CONFIG, 16'd9, int'(`USB_CFG_DESC_BASE), int'(`USB_CFG_DESC_LEN),
                  1'b0);
    reportTest("config descriptor, truncated");
    getDescriptor(`USB_DESC_CONFIG, 16'd32, int'(`USB_CFG_DESC_BASE), int'(`USB_CFG_DESC_LEN),
                  1'b1);
    reportTest("config descriptor under back-pressure");
    stallRequest();
    reportTest("unsupported descriptor");
    setAddress();
    reportTest("set address");
    $display("%0d tests passed, %0d failed, %0d errors", passCnt, failCnt, errCnt);
    if (failCnt == 0 && errCnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
